// ==== compile.f ====
rtl/bp_pkg.sv
rtl/bpht.sv
rtl/tage_index_hash.sv
rtl/tage_bank.sv
rtl/tage_provider_select.sv
rtl/tage.sv
rtl/aim_predictor.sv
dv/aim_predictor_tb.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing -j 0
TOP      ?= aim_predictor_tb
FILELIST ?= compile.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP), log in $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/aim_predictor_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module aim_predictor_tb;

    localparam int h_width    = 8;
    localparam int bh_width   = 16;
    localparam int addr_width = 30;
    localparam int gh_width   = 32;

    typedef struct packed {
        logic [2:0]            kind_pdc;
        logic [addr_width-1:0] pc;
        logic [bh_width-1:0]   bh;
        logic                  upd;
        logic [2:0]            kind_ex;
        logic                  taken;
        logic                  exp_taken;
        logic [1:0]            exp_cnt;
    } row_t;

    logic clk;
    logic rst_n;
    logic stall;
    logic update_en;
    logic [addr_width-1:0] pc_ex;
    logic [bh_width-1:0]   bh_ex;
    logic [gh_width-1:0]   gh_ex;
    logic [2:0]            kind_ex;
    logic                  taken_real;
    logic [1:0]            taken_pdch_ex_b;
    logic                  taken_pdc_ex;
    logic [11:0]           tage_pdch_ex;
    logic [2:0]            kind_pdc;
    logic                  taken_pdc;
    logic [1:0]            taken_pdch_b;
    logic [11:0]           tage_pdch;
    logic [gh_width-1:0]   gh;
    logic [addr_width-1:0] pc;
    logic [bh_width-1:0]   bh_reg;
    logic [addr_width-1:0] pc_reg;

    row_t       rows[$];
    row_t       r;
    logic [1:0] model [1 << h_width];
    logic [11:0] exp_meta;
    int         n_tests;
    int         n_checks;
    int         n_errors;
    int         errs_before;

    aim_predictor #(
        .h_width   (h_width),
        .bh_width  (bh_width),
        .addr_width(addr_width),
        .gh_width  (gh_width)
    ) i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .update_en      (update_en),
        .pc_ex          (pc_ex),
        .bh_ex          (bh_ex),
        .gh_ex          (gh_ex),
        .kind_ex        (kind_ex),
        .taken_real     (taken_real),
        .taken_pdch_ex_b(taken_pdch_ex_b),
        .taken_pdc_ex   (taken_pdc_ex),
        .tage_pdch_ex   (tage_pdch_ex),
        .kind_pdc       (kind_pdc),
        .taken_pdc      (taken_pdc),
        .taken_pdch_b   (taken_pdch_b),
        .tage_pdch      (tage_pdch),
        .gh             (gh),
        .pc             (pc),
        .bh_reg         (bh_reg),
        .pc_reg         (pc_reg)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // counter index: low bits of pc xor local history
    function automatic logic [h_width-1:0] model_idx(
        input logic [addr_width-1:0] p,
        input logic [bh_width-1:0]   b
    );
        return p[h_width-1:0] ^ b[h_width-1:0];
    endfunction

    function automatic logic [1:0] sat_step(input logic [1:0] c, input logic t);
        if (t) begin
            return (c == 2'b11) ? 2'b11 : c + 2'd1;
        end
        return (c == 2'b00) ? 2'b00 : c - 2'd1;
    endfunction

    task automatic check_eq(input logic [31:0] exp, input logic [31:0] got, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail at %0t ns: %s expected %0h got %0h", $time, what, exp, got);
        end
    endtask

    task automatic add_row(input logic [2:0] k, input logic [addr_width-1:0] p,
                           input logic [bh_width-1:0] b, input logic u, input logic [2:0] kx,
                           input logic t, input logic et, input logic [1:0] ec);
        row_t n;
        n = '{k, p, b, u, kx, t, et, ec};
        rows.push_back(n);
    endtask

    task automatic finish_test(input string name);
        n_tests++;
        $display("test %-10s %s (%0d errors)", name,
                 (n_errors == errs_before) ? "ok" : "bad", n_errors - errs_before);
        errs_before = n_errors;
    endtask

    task automatic wait_reset_done();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 || taken_pdch_b === 2'bxx) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20) begin
                $display("timeout: predictor did not come out of reset");
                $display("TEST FAIL");
                $finish;
            end
        end
    endtask

    // lookup and check, then send the update back with the model's counter
    task automatic apply_row(input row_t x);
        logic [h_width-1:0] i;
        i = model_idx(x.pc, x.bh);
        @(posedge clk);
        kind_pdc <= x.kind_pdc;
        pc_reg   <= x.pc;
        bh_reg   <= x.bh;
        @(negedge clk);
        check_eq(32'(x.exp_taken), 32'(taken_pdc), "taken_pdc");
        check_eq(32'(x.exp_cnt), 32'(taken_pdch_b), "taken_pdch_b");
        @(posedge clk);
        update_en       <= x.upd;
        kind_ex         <= x.kind_ex;
        taken_real      <= x.taken;
        taken_pdc_ex    <= x.taken;
        pc_ex           <= x.pc;
        bh_ex           <= x.bh;
        taken_pdch_ex_b <= model[i];
        if (x.upd && x.kind_ex == bp_pkg::direct_jump) begin
            model[i] = sat_step(model[i], x.taken);
        end
        @(posedge clk);
        update_en <= 1'b0;
        kind_ex   <= bp_pkg::not_jump;
    endtask

    initial begin
        void'($urandom(32'h0c7b_36ee));
        n_tests = 0;
        n_checks = 0;
        n_errors = 0;
        errs_before = 0;
        rst_n = 1'b0;
        stall = 1'b0;
        update_en = 1'b0;
        pc_ex = '0;
        bh_ex = '0;
        gh_ex = '0;
        kind_ex = bp_pkg::not_jump;
        taken_real = 1'b0;
        taken_pdch_ex_b = 2'b00;
        taken_pdc_ex = 1'b0;
        tage_pdch_ex = '0;
        kind_pdc = bp_pkg::not_jump;
        gh = '0;
        pc = '0;
        bh_reg = '0;
        pc_reg = '0;
        for (int i = 0; i < (1 << h_width); i++) begin
            model[i] = bp_pkg::ctr_weak_nt;
        end

        // kinds after reset, then saturate up and down at one entry
        add_row(bp_pkg::direct_jump, 30'h100, 16'h23, 0, bp_pkg::not_jump, 0, 0, 2'b01);
        add_row(bp_pkg::ret, 30'h100, 16'h23, 0, bp_pkg::not_jump, 0, 1, 2'b01);
        add_row(bp_pkg::indirect_jump, 30'h100, 16'h23, 0, bp_pkg::not_jump, 0, 1, 2'b01);
        add_row(bp_pkg::call, 30'h100, 16'h23, 0, bp_pkg::not_jump, 0, 1, 2'b01);
        add_row(bp_pkg::jump, 30'h100, 16'h23, 0, bp_pkg::not_jump, 0, 1, 2'b01);
        add_row(bp_pkg::not_jump, 30'h100, 16'h23, 0, bp_pkg::not_jump, 0, 0, 2'b01);
        add_row(bp_pkg::direct_jump, 30'h100, 16'h23, 1, bp_pkg::direct_jump, 1, 0, 2'b01);
        add_row(bp_pkg::direct_jump, 30'h100, 16'h23, 1, bp_pkg::direct_jump, 1, 1, 2'b10);
        add_row(bp_pkg::direct_jump, 30'h100, 16'h23, 0, bp_pkg::not_jump, 0, 1, 2'b11);
        add_row(bp_pkg::not_jump, 30'h100, 16'h23, 0, bp_pkg::not_jump, 0, 0, 2'b11);
        add_row(bp_pkg::direct_jump, 30'h100, 16'h23, 1, bp_pkg::direct_jump, 0, 1, 2'b11);
        add_row(bp_pkg::direct_jump, 30'h100, 16'h23, 1, bp_pkg::direct_jump, 0, 1, 2'b10);
        add_row(bp_pkg::direct_jump, 30'h100, 16'h23, 1, bp_pkg::direct_jump, 0, 0, 2'b01);
        add_row(bp_pkg::direct_jump, 30'h100, 16'h23, 1, bp_pkg::direct_jump, 0, 0, 2'b00);
        // strobe with wrong kind, then right kind with no strobe
        add_row(bp_pkg::direct_jump, 30'h100, 16'h23, 1, bp_pkg::call, 1, 0, 2'b00);
        add_row(bp_pkg::direct_jump, 30'h100, 16'h23, 0, bp_pkg::direct_jump, 1, 0, 2'b00);
        add_row(bp_pkg::direct_jump, 30'h100, 16'h23, 0, bp_pkg::not_jump, 0, 0, 2'b00);
        // 0x2aa/0 and 0xf0a/0xffa0 alias to index 0xaa, 0x155 does not
        add_row(bp_pkg::direct_jump, 30'h2aa, 16'h0, 1, bp_pkg::direct_jump, 1, 0, 2'b01);
        add_row(bp_pkg::direct_jump, 30'h155, 16'h0, 0, bp_pkg::not_jump, 0, 0, 2'b01);
        add_row(bp_pkg::direct_jump, 30'hf0a, 16'hffa0, 0, bp_pkg::not_jump, 0, 1, 2'b10);
        add_row(bp_pkg::direct_jump, 30'hf0a, 16'hffa0, 1, bp_pkg::direct_jump, 1, 1, 2'b10);
        add_row(bp_pkg::direct_jump, 30'h2aa, 16'h0, 0, bp_pkg::not_jump, 0, 1, 2'b11);
        add_row(bp_pkg::direct_jump, 30'h100, 16'h23, 0, bp_pkg::not_jump, 0, 0, 2'b00);

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        wait_reset_done();

        // tage metadata stays zero until an entry is allocated
        @(posedge clk);
        pc <= 30'h0001_2345;
        gh <= 32'hdead_beef;
        @(posedge clk);
        @(negedge clk);
        check_eq(32'h0, 32'(tage_pdch), "tage_pdch after lookup");
        // mispredicted direct jump with no provider allocates bank 0
        @(posedge clk);
        update_en       <= 1'b1;
        kind_ex         <= bp_pkg::direct_jump;
        taken_real      <= 1'b1;
        taken_pdc_ex    <= 1'b0;
        tage_pdch_ex    <= '0;
        pc_ex           <= 30'h0001_2345;
        bh_ex           <= '0;
        gh_ex           <= 32'hdead_beef;
        taken_pdch_ex_b <= model[model_idx(30'h0001_2345, 16'h0)];
        model[model_idx(30'h0001_2345, 16'h0)] =
            sat_step(model[model_idx(30'h0001_2345, 16'h0)], 1'b1);
        @(posedge clk);
        update_en <= 1'b0;
        kind_ex   <= bp_pkg::not_jump;
        @(posedge clk);
        @(negedge clk);
        // provider bank 0, weak taken, local counter at pc_reg not taken
        exp_meta = {1'b1, 2'd0, 3'b100, 1'b0, 4'b0001, 1'b0};
        check_eq(32'(exp_meta), 32'(tage_pdch), "tage_pdch after allocation");
        @(posedge clk);
        stall <= 1'b1;
        pc    <= 30'h0abc_0f0f;
        gh    <= 32'h1234_5678;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_eq(32'(exp_meta), 32'(tage_pdch), "tage_pdch under stall");
        @(posedge clk);
        stall <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_eq(32'h0, 32'(tage_pdch), "tage_pdch after stall");
        finish_test("tage");

        foreach (rows[k]) begin
            apply_row(rows[k]);
        end
        finish_test("table");

        // random trained direct jumps over a few aliasing entries
        for (int k = 0; k < 40; k++) begin
            r.kind_pdc = bp_pkg::direct_jump;
            r.pc = 30'($urandom());
            r.pc[7:2] = '0;
            r.bh = 16'($urandom());
            r.bh[7:2] = '0;
            r.upd = 1'b1;
            r.kind_ex = bp_pkg::direct_jump;
            r.taken = 1'($urandom());
            r.exp_cnt = model[model_idx(r.pc, r.bh)];
            r.exp_taken = r.exp_cnt[1];
            apply_row(r);
        end
        finish_test("random");

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/aim_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module aim_predictor #(
    parameter int h_width    = 8,
    parameter int bh_width   = 16,
    parameter int addr_width = 30,
    parameter int gh_width   = 32
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  stall,
    input  wire                  update_en,
    // ex stage
    input  wire [addr_width-1:0] pc_ex,
    input  wire [bh_width-1:0]   bh_ex,
    input  wire [gh_width-1:0]   gh_ex,
    input  wire bp_pkg::kind_t   kind_ex,
    input  wire                  taken_real,
    input  wire [1:0]            taken_pdch_ex_b,
    input  wire                  taken_pdc_ex,
    input  wire [11:0]           tage_pdch_ex,
    // prediction
    input  wire bp_pkg::kind_t   kind_pdc,
    output logic                 taken_pdc,
    output logic [1:0]           taken_pdch_b,
    output logic [11:0]          tage_pdch,
    // current fetch
    input  wire [gh_width-1:0]   gh,
    input  wire [addr_width-1:0] pc,
    input  wire [bh_width-1:0]   bh_reg,
    input  wire [addr_width-1:0] pc_reg
);

    logic taken_b;
    logic upd_direct;

    // only direct jumps train the predictors
    assign upd_direct = update_en && (kind_ex == bp_pkg::direct_jump);

    bpht #(
        .h_width   (h_width),
        .bh_width  (bh_width),
        .addr_width(addr_width)
    ) u_bpht (
        .clk            (clk),
        .rst_n          (rst_n),
        .update_en      (upd_direct),
        .pc             (pc_reg),
        .bh             (bh_reg),
        .b_taken_pdc    (taken_b),
        .taken_pdch_b   (taken_pdch_b),
        .b_taken_real   (taken_real),
        .taken_pdch_ex_b(taken_pdch_ex_b),
        .pc_update      (pc_ex),
        .bh_update      (bh_ex)
    );

    // tage direction is carried in the metadata only for now
    tage #(
        .h_width   (h_width),
        .addr_width(addr_width),
        .gh_width  (gh_width)
    ) u_tage (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .update_en   (upd_direct),
        .pc          (pc),
        .gh          (gh),
        .taken_bh    (taken_b),
        .pc_ex       (pc_ex),
        .gh_ex       (gh_ex),
        .taken_ex    (taken_real),
        .taken_pdc_ex(taken_pdc_ex),
        .pdch_ex     (tage_pdch_ex),
        .taken_pdc   (),
        .pdch        (tage_pdch)
    );

    // kinds 4..7 always taken, direct jump follows the local counter
    assign taken_pdc = kind_pdc[2] | (kind_pdc[0] & taken_b);

endmodule

`default_nettype wire

// ==== rtl/tage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tage #(
    parameter int h_width    = 8,
    parameter int addr_width = 30,
    parameter int gh_width   = 32
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  stall,
    input  wire                  update_en,
    input  wire [addr_width-1:0] pc,
    input  wire [gh_width-1:0]   gh,
    input  wire                  taken_bh,
    input  wire [addr_width-1:0] pc_ex,
    input  wire [gh_width-1:0]   gh_ex,
    input  wire                  taken_ex,
    input  wire                  taken_pdc_ex,
    input  wire [11:0]           pdch_ex,
    output logic                 taken_pdc,
    output logic [11:0]          pdch
);

    localparam int nb = bp_pkg::tage_banks;

    logic [nb-1:0][h_width-1:0]                idx;
    logic [nb-1:0][bp_pkg::tage_tag_width-1:0] tag;
    logic [nb-1:0][h_width-1:0]                idx_ex;
    logic [nb-1:0][bp_pkg::tage_tag_width-1:0] tag_ex;
    logic [nb-1:0]                             hit;
    logic [nb-1:0][2:0]                        ctr;
    logic [nb-1:0]                             useful;
    logic [nb-1:0]                             upd_en;
    logic [nb-1:0]                             alloc_en;
    logic                                      mispredict;
    bp_pkg::tage_meta_t                        meta_ex;

    assign meta_ex    = pdch_ex;
    assign mispredict = (taken_pdc_ex != taken_ex);

    tage_index_hash #(
        .h_width   (h_width),
        .addr_width(addr_width),
        .gh_width  (gh_width)
    ) u_hash (
        .pc    (pc),
        .gh    (gh),
        .pc_ex (pc_ex),
        .gh_ex (gh_ex),
        .idx   (idx),
        .tag   (tag),
        .idx_ex(idx_ex),
        .tag_ex(tag_ex)
    );

    // provider steps its counter; on a miss, allocate the first free longer bank
    always_comb begin
        logic found;
        found    = 1'b0;
        upd_en   = '0;
        alloc_en = '0;
        for (int b = 0; b < nb; b++) begin
            upd_en[b] = update_en && meta_ex.provider_valid
                        && (meta_ex.provider_bank == 2'(b));
            if (update_en && mispredict && !found && !meta_ex.hit[b] && !useful[b]
                && (!meta_ex.provider_valid || b > int'(meta_ex.provider_bank))) begin
                alloc_en[b] = 1'b1;
                found       = 1'b1;
            end
        end
    end

    for (genvar b = 0; b < nb; b++) begin : g_bank
        tage_bank #(
            .h_width (h_width),
            .hist_len(bp_pkg::tage_hist_len[b])
        ) u_bank (
            .clk      (clk),
            .rst_n    (rst_n),
            .stall    (stall),
            .idx      (idx[b]),
            .tag      (tag[b]),
            .hit      (hit[b]),
            .ctr      (ctr[b]),
            .upd_idx  (idx_ex[b]),
            .upd_tag  (tag_ex[b]),
            .upd_en   (upd_en[b]),
            .alloc_en (alloc_en[b]),
            .upd_taken(taken_ex),
            .upd_ctr  (meta_ex.provider_ctr),
            .useful   (useful[b])
        );
    end

    tage_provider_select u_select (
        .hit      (hit),
        .ctr      (ctr),
        .taken_bh (taken_bh),
        .taken_pdc(taken_pdc),
        .pdch     (pdch)
    );

endmodule

`default_nettype wire

// ==== rtl/tage_provider_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module tage_provider_select (
    input  wire [bp_pkg::tage_banks-1:0]      hit,
    input  wire [bp_pkg::tage_banks-1:0][2:0] ctr,
    input  wire                               taken_bh,
    output logic                              taken_pdc,
    output logic [11:0]                       pdch
);

    bp_pkg::tage_meta_t meta;

    logic       prov_valid;
    logic [1:0] prov;
    logic       alt_valid;
    logic [1:0] alt;
    logic       alt_taken;

    // later banks have longer history, so the last hit wins
    always_comb begin
        prov_valid = 1'b0;
        prov       = 2'd0;
        alt_valid  = 1'b0;
        alt        = 2'd0;
        for (int b = 0; b < bp_pkg::tage_banks; b++) begin
            if (hit[b]) begin
                alt_valid  = prov_valid;
                alt        = prov;
                prov_valid = 1'b1;
                prov       = 2'(b);
            end
        end
    end

    // alternate falls back to the local predictor
    always_comb begin
        if (!prov_valid) begin
            alt_taken = 1'b0;
        end else if (alt_valid) begin
            alt_taken = ctr[alt][2];
        end else begin
            alt_taken = taken_bh;
        end
    end

    assign taken_pdc = prov_valid ? ctr[prov][2] : taken_bh;

    always_comb begin
        meta.provider_valid = prov_valid;
        meta.provider_bank  = prov;
        meta.provider_ctr   = prov_valid ? ctr[prov] : 3'b000;
        meta.alt_taken      = alt_taken;
        meta.hit            = hit;
        meta.spare          = 1'b0;
    end

    assign pdch = meta;

endmodule

`default_nettype wire

// ==== rtl/tage_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module tage_bank #(
    parameter int h_width  = 8,
    parameter int hist_len = 4
) (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              stall,
    // lookup
    input  wire [h_width-1:0]                idx,
    input  wire [bp_pkg::tage_tag_width-1:0] tag,
    output logic                             hit,
    output logic [2:0]                       ctr,
    // update / allocate
    input  wire [h_width-1:0]                upd_idx,
    input  wire [bp_pkg::tage_tag_width-1:0] upd_tag,
    input  wire                              upd_en,
    input  wire                              alloc_en,
    input  wire                              upd_taken,
    input  wire [2:0]                        upd_ctr,
    output logic                             useful
);

    localparam int depth     = 1 << h_width;
    localparam int tw        = bp_pkg::tage_tag_width;
    // short-history banks keep a shorter tag
    localparam int used_bits = (hist_len < tw) ? hist_len : tw;
    localparam logic [tw-1:0] tag_mask = {tw{1'b1}} >> (tw - used_bits);

    logic          valid      [depth];
    logic          useful_mem [depth];
    logic [tw-1:0] tag_mem    [depth];
    logic [2:0]    ctr_mem    [depth];
    logic [2:0]    next_ctr;
    logic          upd_correct;

    assign upd_correct = (upd_ctr[2] == upd_taken);
    assign useful      = useful_mem[upd_idx];

    always_comb begin
        if (upd_taken) begin
            next_ctr = (upd_ctr == 3'b111) ? 3'b111 : upd_ctr + 3'd1;
        end else begin
            next_ctr = (upd_ctr == 3'b000) ? 3'b000 : upd_ctr - 3'd1;
        end
    end

    // lookup result, frozen while stalled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hit <= 1'b0;
            ctr <= 3'b000;
        end else if (!stall) begin
            hit <= valid[idx] && (tag_mem[idx] == (tag & tag_mask));
            ctr <= ctr_mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                valid[i]      <= 1'b0;
                useful_mem[i] <= 1'b0;
            end
        end else if (alloc_en) begin
            valid[upd_idx]      <= 1'b1;
            useful_mem[upd_idx] <= 1'b0;
        end else if (upd_en && upd_correct) begin
            useful_mem[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            tag_mem[upd_idx] <= upd_tag & tag_mask;
            // weak, leaning the resolved way
            ctr_mem[upd_idx] <= upd_taken ? 3'b100 : 3'b011;
        end else if (upd_en) begin
            ctr_mem[upd_idx] <= next_ctr;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tage_index_hash.sv ====
`timescale 1ns/1ps
`default_nettype none

module tage_index_hash #(
    parameter int h_width    = 8,
    parameter int addr_width = 30,
    parameter int gh_width   = 32
) (
    input  wire [addr_width-1:0] pc,
    input  wire [gh_width-1:0]   gh,
    input  wire [addr_width-1:0] pc_ex,
    input  wire [gh_width-1:0]   gh_ex,
    output logic [bp_pkg::tage_banks-1:0][h_width-1:0]                idx,
    output logic [bp_pkg::tage_banks-1:0][bp_pkg::tage_tag_width-1:0] tag,
    output logic [bp_pkg::tage_banks-1:0][h_width-1:0]                idx_ex,
    output logic [bp_pkg::tage_banks-1:0][bp_pkg::tage_tag_width-1:0] tag_ex
);

    localparam int tw = bp_pkg::tage_tag_width;

    // xor the first len history bits into a w-bit window
    function automatic logic [gh_width-1:0] fold(
        input logic [gh_width-1:0] g,
        input int                  len,
        input int                  w
    );
        logic [gh_width-1:0] r;
        r = '0;
        for (int j = 0; j < gh_width; j++) begin
            if (j < len) begin
                r[j % w] = r[j % w] ^ g[j];
            end
        end
        return r;
    endfunction

    function automatic logic [h_width-1:0] make_idx(
        input logic [addr_width-1:0] p,
        input logic [gh_width-1:0]   g,
        input int                    len
    );
        logic [gh_width-1:0] f;
        f = fold(g, len, h_width);
        return p[h_width-1:0] ^ f[h_width-1:0];
    endfunction

    // second fold one bit narrower, shifted, so tag and index decorrelate
    function automatic logic [tw-1:0] make_tag(
        input logic [addr_width-1:0] p,
        input logic [gh_width-1:0]   g,
        input int                    len
    );
        logic [gh_width-1:0] f1;
        logic [gh_width-1:0] f2;
        f1 = fold(g, len, tw);
        f2 = fold(g, len, tw - 1);
        return p[h_width +: tw] ^ f1[tw-1:0] ^ {f2[tw-2:0], 1'b0};
    endfunction

    for (genvar b = 0; b < bp_pkg::tage_banks; b++) begin : g_hash
        assign idx[b]    = make_idx(pc, gh, bp_pkg::tage_hist_len[b]);
        assign tag[b]    = make_tag(pc, gh, bp_pkg::tage_hist_len[b]);
        assign idx_ex[b] = make_idx(pc_ex, gh_ex, bp_pkg::tage_hist_len[b]);
        assign tag_ex[b] = make_tag(pc_ex, gh_ex, bp_pkg::tage_hist_len[b]);
    end

endmodule

`default_nettype wire

// ==== rtl/bpht.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpht #(
    parameter int h_width    = 8,
    parameter int bh_width   = 16,
    parameter int addr_width = 30
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  update_en,
    // lookup
    input  wire [addr_width-1:0] pc,
    input  wire [bh_width-1:0]   bh,
    output logic                 b_taken_pdc,
    output logic [1:0]           taken_pdch_b,
    // ex stage training
    input  wire                  b_taken_real,
    input  wire [1:0]            taken_pdch_ex_b,
    input  wire [addr_width-1:0] pc_update,
    input  wire [bh_width-1:0]   bh_update
);

    localparam int depth = 1 << h_width;

    logic [1:0]         cnt [depth];
    logic [h_width-1:0] rd_idx;
    logic [h_width-1:0] wr_idx;
    logic [1:0]         next_cnt;

    // pc xor local history, low bits only
    assign rd_idx = pc[h_width-1:0] ^ bh[h_width-1:0];
    assign wr_idx = pc_update[h_width-1:0] ^ bh_update[h_width-1:0];

    assign taken_pdch_b = cnt[rd_idx];
    assign b_taken_pdc  = taken_pdch_b[1];

    // step the counter that travelled with the branch
    always_comb begin
        if (b_taken_real) begin
            if (taken_pdch_ex_b == 2'b11) begin
                next_cnt = 2'b11;
            end else begin
                next_cnt = taken_pdch_ex_b + 2'd1;
            end
        end else begin
            if (taken_pdch_ex_b == 2'b00) begin
                next_cnt = 2'b00;
            end else begin
                next_cnt = taken_pdch_ex_b - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                cnt[i] <= bp_pkg::ctr_weak_nt;
            end
        end else if (update_en) begin
            cnt[wr_idx] <= next_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

    // branch kind codes from predecode
    typedef logic [2:0] kind_t;

    localparam kind_t not_jump      = 3'd0;
    localparam kind_t direct_jump   = 3'd1;
    localparam kind_t ret           = 3'd4;
    localparam kind_t indirect_jump = 3'd5;
    localparam kind_t call          = 3'd6;
    localparam kind_t jump          = 3'd7;

    // 2-bit local counter reset value
    localparam logic [1:0] ctr_weak_nt = 2'b01;

    // tagged table geometry
    localparam int tage_banks     = 4;
    localparam int tage_tag_width = 8;
    localparam int tage_hist_len [tage_banks] = '{4, 8, 16, 32};

    // metadata carried with the branch down the pipe
    typedef struct packed {
        logic                  provider_valid;
        logic [1:0]            provider_bank;
        logic [2:0]            provider_ctr;
        logic                  alt_taken;
        logic [tage_banks-1:0] hit;
        logic                  spare;
    } tage_meta_t;

endpackage

`default_nettype wire
